/* hdl/rv_pkg.sv */
package rv_pkg;

	// ----------------------------------------
	// Encodings
	// ----------------------------------------

	typedef enum logic [6:0] {
		OPC_LOAD     = 7'b0000011,
		OPC_MISC_MEM = 7'b0001111, // FENCE.I lives here
		OPC_OP_IMM   = 7'b0010011,
		OPC_AUIPC    = 7'b0010111,
		OPC_STORE    = 7'b0100011,
		OPC_OP       = 7'b0110011,
		OPC_LUI      = 7'b0110111,
		OPC_BRANCH   = 7'b1100011,
		OPC_JALR     = 7'b1100111,
		OPC_JAL      = 7'b1101111,
		OPC_SYSTEM   = 7'b1110011
	} opcode_e;

	// Codes 0 to 7 are funct3 of OP
	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SLL  = 4'd1,
		ALU_SLT  = 4'd2,
		ALU_SLTU = 4'd3,
		ALU_XOR  = 4'd4,
		ALU_SRL  = 4'd5,
		ALU_OR   = 4'd6,
		ALU_AND  = 4'd7,
		ALU_SUB  = 4'd8,
		ALU_EQ   = 4'd9,  // Branch compares fill the gaps
		ALU_NEQ  = 4'd10,
		ALU_LT   = 4'd11,
		ALU_GE   = 4'd12,
		ALU_SRA  = 4'd13,
		ALU_LTU  = 4'd14,
		ALU_GEU  = 4'd15
	} alu_op_e;

	typedef enum logic [2:0] {
		MEM_RD_NONE, MEM_RD_BYTE, MEM_RD_HALF, MEM_RD_WORD, MEM_RD_BYTE_U, MEM_RD_HALF_U
	} mem_read_e;

	typedef enum logic [1:0] {
		MEM_WR_NONE, MEM_WR_BYTE, MEM_WR_HALF, MEM_WR_WORD
	} mem_write_e;

	typedef enum logic [2:0] {
		CSR_NONE, CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE, CSR_MVENDORID, CSR_MARCHID
	} csr_id_e;

	localparam logic [11:0] F12_ECALL  = 12'h000;
	localparam logic [11:0] F12_EBREAK = 12'h001;
	localparam logic [11:0] F12_MRET   = 12'h302;

	localparam logic [11:0] CSR_ADDR_MSTATUS   = 12'h300;
	localparam logic [11:0] CSR_ADDR_MTVEC     = 12'h305;
	localparam logic [11:0] CSR_ADDR_MEPC      = 12'h341;
	localparam logic [11:0] CSR_ADDR_MCAUSE    = 12'h342;
	localparam logic [11:0] CSR_ADDR_MVENDORID = 12'hF11;
	localparam logic [11:0] CSR_ADDR_MARCHID   = 12'hF12;

	// Lower slot index means a younger stage
	localparam int STAGE_EXU = 0;
	localparam int STAGE_LSU = 1;
	localparam int STAGE_WBU = 2;
	localparam int NUM_SLOTS = 3;

	// ----------------------------------------
	// Instruction formats
	// ----------------------------------------

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		opcode_e    opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		opcode_e     opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_11_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_4_0;
		opcode_e    opcode;
	} s_fmt_t;

	typedef struct packed {
		logic       imm_12;
		logic [5:0] imm_10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm_4_1;
		logic       imm_11;
		opcode_e    opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm_31_12;
		logic [4:0]  rd;
		opcode_e     opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm_20;
		logic [9:0] imm_10_1;
		logic       imm_11;
		logic [7:0] imm_19_12;
		logic [4:0] rd;
		opcode_e    opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} inst_u;

	// ----------------------------------------
	// Stage bundles
	// ----------------------------------------

	typedef struct packed {
		inst_u       inst;
		logic [31:0] pc;
	} fetch_t;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] src1;
		logic [31:0] src2;
		logic [31:0] store_data;
		logic [31:0] imm;
		logic [3:0]  rd;
		alu_op_e     alu_op;
		logic        reg_write;
		logic        csr_write;
		logic        is_jump;
		logic        is_jalr;    // Target taken from the ALU sum
		mem_read_e   mem_read;
		mem_write_e  mem_write;
		logic        ecall;
		logic        ebreak;
		logic        mret;
		logic        fence_i;
		csr_id_e     csr_rd_id;
		csr_id_e     csr_wr_id;
	} decoded_t;

	typedef struct packed {
		logic [3:0]  rd;
		logic        rd_valid;
		csr_id_e     csr_id;
		logic        csr_valid;
		logic [31:0] fwd_data;
		logic        fwd_valid;  // Result already computed
	} pipe_slot_t;

	typedef struct packed {
		logic [3:0]  rd;
		logic        rd_we;
		logic [31:0] rd_data;
		csr_id_e     csr_id;
		logic        csr_we;
		logic [31:0] csr_data;
	} wb_t;

endpackage

/* hdl/inst_decoder.sv */
module inst_decoder import rv_pkg::*; (
	input  fetch_t      fetch,
	input  logic [31:0] rs1_val,
	input  logic [31:0] rs2_val,
	input  logic [31:0] csr_val,
	output logic [3:0]  rs1,
	output logic [3:0]  rs2,
	output logic        uses_rs1,
	output logic        uses_rs2,
	output logic        is_csrr,
	output csr_id_e     csr_rd_id,
	output decoded_t    dec
);

	inst_u       inst;
	opcode_e     opcode;
	logic [2:0]  funct3;
	logic        funct7_5;
	logic [11:0] funct12;
	logic        is_sys0;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;
	csr_id_e     csr_addr_id;
	csr_id_e     csr_wr_id;

	assign inst     = fetch.inst;
	assign opcode   = inst.r_fmt.opcode;
	assign funct3   = inst.r_fmt.funct3;
	assign funct7_5 = inst.r_fmt.funct7[5];
	assign funct12  = inst.i_fmt.imm;
	assign is_sys0  = (opcode == OPC_SYSTEM) && (funct3 == 3'b000);

	assign rs1 = inst.r_fmt.rs1[3:0]; // RV32E has 16 registers
	assign rs2 = inst.r_fmt.rs2[3:0];

	// ----------------------------------------
	// Immediates
	// ----------------------------------------
	assign imm_i = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
	assign imm_s = {{20{inst.s_fmt.imm_11_5[6]}}, inst.s_fmt.imm_11_5, inst.s_fmt.imm_4_0};
	assign imm_b = {{20{inst.b_fmt.imm_12}}, inst.b_fmt.imm_11, inst.b_fmt.imm_10_5,
		inst.b_fmt.imm_4_1, 1'b0};
	assign imm_u = {inst.u_fmt.imm_31_12, 12'b0};
	assign imm_j = {{12{inst.j_fmt.imm_20}}, inst.j_fmt.imm_19_12, inst.j_fmt.imm_11,
		inst.j_fmt.imm_10_1, 1'b0};

	// ----------------------------------------
	// CSR ids
	// ----------------------------------------
	always_comb begin
		case (funct12)
			CSR_ADDR_MSTATUS:   csr_addr_id = CSR_MSTATUS;
			CSR_ADDR_MTVEC:     csr_addr_id = CSR_MTVEC;
			CSR_ADDR_MEPC:      csr_addr_id = CSR_MEPC;
			CSR_ADDR_MCAUSE:    csr_addr_id = CSR_MCAUSE;
			CSR_ADDR_MVENDORID: csr_addr_id = CSR_MVENDORID;
			CSR_ADDR_MARCHID:   csr_addr_id = CSR_MARCHID;
			default:            csr_addr_id = CSR_NONE; // Unknown address
		endcase
	end

	always_comb begin
		csr_rd_id = CSR_NONE;
		csr_wr_id = CSR_NONE;
		if (is_sys0 && funct12 == F12_ECALL) begin
			csr_rd_id = CSR_MTVEC; // Jump to trap vector
			csr_wr_id = CSR_MEPC;  // Save return pc
		end else if (is_sys0 && funct12 == F12_MRET) begin
			csr_rd_id = CSR_MEPC;
		end else if (opcode == OPC_SYSTEM && !is_sys0) begin
			csr_rd_id = csr_addr_id;
			csr_wr_id = csr_addr_id;
		end
	end

	// ----------------------------------------
	// Control and operands
	// ----------------------------------------
	always_comb begin
		dec            = '0;
		dec.pc         = fetch.pc;
		dec.rd         = inst.r_fmt.rd[3:0];
		dec.src1       = rs1_val;
		dec.src2       = rs2_val;
		dec.store_data = rs2_val; // Forwarded store value
		dec.alu_op     = ALU_ADD;
		dec.mem_read   = MEM_RD_NONE;
		dec.mem_write  = MEM_WR_NONE;
		dec.csr_rd_id  = csr_rd_id;
		dec.csr_wr_id  = csr_wr_id;
		uses_rs1       = 1'b0;
		uses_rs2       = 1'b0;
		is_csrr        = 1'b0;
		case (opcode)
			OPC_OP: begin
				dec.reg_write = 1'b1;
				dec.alu_op    = alu_op_e'({funct7_5, funct3}); // SUB and SRA via funct7
				uses_rs1      = 1'b1;
				uses_rs2      = 1'b1;
			end
			OPC_OP_IMM: begin
				dec.imm       = imm_i;
				dec.src2      = imm_i;
				dec.reg_write = 1'b1;
				dec.alu_op    = alu_op_e'({(funct3 == 3'b101) && funct7_5, funct3}); // SRAI only
				uses_rs1      = 1'b1;
			end
			OPC_LOAD: begin
				dec.imm       = imm_i;
				dec.src2      = imm_i; // Address sum
				dec.reg_write = 1'b1;
				uses_rs1      = 1'b1;
				case (funct3)
					3'b000:  dec.mem_read = MEM_RD_BYTE;
					3'b001:  dec.mem_read = MEM_RD_HALF;
					3'b010:  dec.mem_read = MEM_RD_WORD;
					3'b100:  dec.mem_read = MEM_RD_BYTE_U;
					3'b101:  dec.mem_read = MEM_RD_HALF_U;
					default: dec.mem_read = MEM_RD_NONE;
				endcase
			end
			OPC_STORE: begin
				dec.imm  = imm_s;
				dec.src2 = imm_s;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1; // Store data
				case (funct3)
					3'b000:  dec.mem_write = MEM_WR_BYTE;
					3'b001:  dec.mem_write = MEM_WR_HALF;
					3'b010:  dec.mem_write = MEM_WR_WORD;
					default: dec.mem_write = MEM_WR_NONE;
				endcase
			end
			OPC_BRANCH: begin
				dec.imm  = imm_b;
				uses_rs1 = 1'b1;
				uses_rs2 = 1'b1;
				case (funct3)
					3'b000:  dec.alu_op = ALU_EQ;
					3'b001:  dec.alu_op = ALU_NEQ;
					3'b100:  dec.alu_op = ALU_LT;
					3'b101:  dec.alu_op = ALU_GE;
					3'b110:  dec.alu_op = ALU_LTU;
					3'b111:  dec.alu_op = ALU_GEU;
					default: dec.alu_op = ALU_ADD;
				endcase
			end
			OPC_JAL: begin
				dec.imm       = imm_j;
				dec.src1      = fetch.pc;
				dec.src2      = imm_j;
				dec.is_jump   = 1'b1;
				dec.is_jalr   = 1'b1; // pc + imm from the ALU
				dec.reg_write = 1'b1;
			end
			OPC_JALR: begin
				dec.imm       = imm_i;
				dec.src2      = imm_i;
				dec.is_jump   = 1'b1;
				dec.is_jalr   = 1'b1;
				dec.reg_write = 1'b1;
				uses_rs1      = 1'b1;
			end
			OPC_LUI: begin
				dec.imm       = imm_u;
				dec.src1      = 32'd0;
				dec.src2      = imm_u;
				dec.reg_write = 1'b1;
			end
			OPC_AUIPC: begin
				dec.imm       = imm_u;
				dec.src1      = fetch.pc;
				dec.src2      = imm_u;
				dec.reg_write = 1'b1;
			end
			OPC_MISC_MEM: begin
				if (funct3 == 3'b001) begin
					dec.imm     = 32'd4; // Refetch from the next word
					dec.fence_i = 1'b1;
				end
			end
			OPC_SYSTEM: begin
				dec.imm = imm_i;
				case (funct3)
					3'b000: begin
						case (funct12)
							F12_EBREAK: dec.ebreak = 1'b1;
							F12_MRET: begin
								dec.mret = 1'b1;
								dec.src1 = csr_val; // mepc
								dec.src2 = 32'd0;
							end
							F12_ECALL: begin
								dec.ecall     = 1'b1;
								dec.csr_write = 1'b1;
								dec.is_jalr   = 1'b1;
								dec.src1      = csr_val; // mtvec
								dec.src2      = 32'd0;
							end
							default: ;
						endcase
					end
					3'b001: begin // CSRRW
						dec.csr_write = 1'b1;
						dec.src2      = 32'd0;
						uses_rs1      = 1'b1;
					end
					3'b010: begin // CSRRS
						is_csrr       = 1'b1;
						dec.reg_write = 1'b1;
						dec.src2      = csr_val;
						dec.alu_op    = ALU_OR;
						uses_rs1      = 1'b1;
					end
					default: ;
				endcase
			end
			default: ;
		endcase
	end

	always_comb begin
		assert final (dec.mem_read == MEM_RD_NONE || dec.mem_write == MEM_WR_NONE)
			else $error("load and store decoded for one instruction");
	end

endmodule

/* hdl/hazard_fwd.sv */
module hazard_fwd import rv_pkg::*; (
	input  logic [3:0]  rs1,
	input  logic [3:0]  rs2,
	input  logic        uses_rs1,
	input  logic        uses_rs2,
	input  logic        is_csrr,
	input  csr_id_e     csr_rd_id,
	input  pipe_slot_t  slots [NUM_SLOTS],
	input  logic [31:0] rf_rs1,
	input  logic [31:0] rf_rs2,
	input  logic        in_valid,
	input  logic        out_ready,
	output logic [31:0] rs1_val,
	output logic [31:0] rs2_val,
	output logic        in_ready,
	output logic        out_valid
);

	logic [NUM_SLOTS-1:0] rs1_hit;
	logic [NUM_SLOTS-1:0] rs2_hit;
	logic [NUM_SLOTS-1:0] csr_hit;
	logic [NUM_SLOTS-1:0] fwd_ok;
	logic                 rs1_stall;
	logic                 rs2_stall;
	logic                 csr_stall;
	logic                 stall;

	// Youngest forwardable producer wins
	function automatic logic [31:0] fwd_sel(
		input logic [NUM_SLOTS-1:0] hit,
		input pipe_slot_t           exu,
		input pipe_slot_t           lsu,
		input pipe_slot_t           wbu,
		input logic [31:0]          rf_val
	);
		logic [31:0] val;
		val = rf_val;
		if (hit[STAGE_EXU] && exu.fwd_valid)
			val = exu.fwd_data;
		else if (hit[STAGE_LSU] && lsu.fwd_valid)
			val = lsu.fwd_data;
		else if (hit[STAGE_WBU] && wbu.fwd_valid)
			val = wbu.fwd_data;
		return val;
	endfunction

	// ----------------------------------------
	// Match against younger stages
	// ----------------------------------------
	always_comb begin
		for (int i = 0; i < NUM_SLOTS; i++) begin
			fwd_ok[i]  = slots[i].fwd_valid;
			rs1_hit[i] = slots[i].rd_valid && (slots[i].rd == rs1) && (rs1 != 4'd0); // Never x0
			rs2_hit[i] = slots[i].rd_valid && (slots[i].rd == rs2) && (rs2 != 4'd0);
			csr_hit[i] = slots[i].csr_valid && (slots[i].csr_id == csr_rd_id);
		end
	end

	assign rs1_val = fwd_sel(rs1_hit, slots[STAGE_EXU], slots[STAGE_LSU], slots[STAGE_WBU],
		rf_rs1);
	assign rs2_val = fwd_sel(rs2_hit, slots[STAGE_EXU], slots[STAGE_LSU], slots[STAGE_WBU],
		rf_rs2);

	// Any unforwardable match stalls, even behind a forwardable younger one
	assign rs1_stall = uses_rs1 && |(rs1_hit & ~fwd_ok);
	assign rs2_stall = uses_rs2 && |(rs2_hit & ~fwd_ok);
	assign csr_stall = is_csrr && (csr_rd_id != CSR_NONE) && |csr_hit; // CSRs never forward
	assign stall     = rs1_stall || rs2_stall || csr_stall;

	// ----------------------------------------
	// Handshake
	// ----------------------------------------
	assign in_ready  = out_ready && !stall;
	assign out_valid = in_valid && out_ready && !stall;

	always_comb begin
		assert final (!(out_valid && !in_ready))
			else $error("instruction passed to execute without being taken from fetch");
	end

endmodule

/* hdl/reg_file.sv */
module reg_file import rv_pkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic [3:0]  rs1,
	input  logic [3:0]  rs2,
	input  wb_t         wb,
	output logic [31:0] rf_rs1,
	output logic [31:0] rf_rs2
);

	logic [31:0] regs [1:15]; // No storage for x0

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 16; i++) begin
				regs[i] <= 32'd0;
			end
		end else if (wb.rd_we && (wb.rd != 4'd0)) begin
			regs[wb.rd] <= wb.rd_data;
		end
	end

	// Visible the cycle after the write
	assign rf_rs1 = (rs1 == 4'd0) ? 32'd0 : regs[rs1];
	assign rf_rs2 = (rs2 == 4'd0) ? 32'd0 : regs[rs2];

	a_x0_stays_zero: assert property (@(posedge clk) disable iff (rst)
		(wb.rd_we && wb.rd == 4'd0) |=> ((rs1 != 4'd0 || rf_rs1 == 32'd0) &&
		(rs2 != 4'd0 || rf_rs2 == 32'd0)))
		else $error("x0 read nonzero after a write to it");

endmodule

/* hdl/csr_file.sv */
module csr_file import rv_pkg::*; #(
	parameter logic [31:0] VENDOR_ID = 32'h0000_0000,
	parameter logic [31:0] ARCH_ID   = 32'h0000_0000
) (
	input  logic        clk,
	input  logic        rst,
	input  csr_id_e     csr_rd_id,
	input  wb_t         wb,
	output logic [31:0] csr_val
);

	logic [31:0] mstatus;
	logic [31:0] mtvec;
	logic [31:0] mepc;
	logic [31:0] mcause;

	// ----------------------------------------
	// Write port from write-back
	// ----------------------------------------
	always_ff @(posedge clk) begin
		if (rst) begin
			mstatus <= 32'd0;
			mtvec   <= 32'd0;
			mepc    <= 32'd0;
			mcause  <= 32'd0;
		end else if (wb.csr_we) begin
			case (wb.csr_id)
				CSR_MSTATUS: mstatus <= wb.csr_data;
				CSR_MTVEC:   mtvec   <= wb.csr_data;
				CSR_MEPC:    mepc    <= wb.csr_data;
				CSR_MCAUSE:  mcause  <= wb.csr_data;
				default: ; // Id registers are read only
			endcase
		end
	end

	// ----------------------------------------
	// Read port
	// ----------------------------------------
	always_comb begin
		case (csr_rd_id)
			CSR_MSTATUS:   csr_val = mstatus;
			CSR_MTVEC:     csr_val = mtvec;
			CSR_MEPC:      csr_val = mepc;
			CSR_MCAUSE:    csr_val = mcause;
			CSR_MVENDORID: csr_val = VENDOR_ID;
			CSR_MARCHID:   csr_val = ARCH_ID;
			default:       csr_val = 32'd0;
		endcase
	end

endmodule

/* hdl/id_top.sv */
module id_top import rv_pkg::*; #(
	parameter logic [31:0] VENDOR_ID = 32'h0000_0000,
	parameter logic [31:0] ARCH_ID   = 32'h0000_0000
) (
	input  logic       clk,
	input  logic       rst,
	input  fetch_t     fetch,
	input  logic       in_valid,
	output logic       in_ready,
	output decoded_t   dec,
	output logic       out_valid,
	input  logic       out_ready,
	input  pipe_slot_t slots [NUM_SLOTS],
	input  wb_t        wb
);

	logic [3:0]  rs1;
	logic [3:0]  rs2;
	logic        uses_rs1;
	logic        uses_rs2;
	logic        is_csrr;
	csr_id_e     csr_rd_id;
	logic [31:0] rs1_val;   // After forwarding
	logic [31:0] rs2_val;
	logic [31:0] rf_rs1;
	logic [31:0] rf_rs2;
	logic [31:0] csr_val;

	inst_decoder u_dec (
		.fetch     (fetch),
		.rs1_val   (rs1_val),
		.rs2_val   (rs2_val),
		.csr_val   (csr_val),
		.rs1       (rs1),
		.rs2       (rs2),
		.uses_rs1  (uses_rs1),
		.uses_rs2  (uses_rs2),
		.is_csrr   (is_csrr),
		.csr_rd_id (csr_rd_id),
		.dec       (dec)
	);

	hazard_fwd u_haz (
		.rs1       (rs1),
		.rs2       (rs2),
		.uses_rs1  (uses_rs1),
		.uses_rs2  (uses_rs2),
		.is_csrr   (is_csrr),
		.csr_rd_id (csr_rd_id),
		.slots     (slots),
		.rf_rs1    (rf_rs1),
		.rf_rs2    (rf_rs2),
		.in_valid  (in_valid),
		.out_ready (out_ready),
		.rs1_val   (rs1_val),
		.rs2_val   (rs2_val),
		.in_ready  (in_ready),
		.out_valid (out_valid)
	);

	reg_file u_rf (
		.clk    (clk),
		.rst    (rst),
		.rs1    (rs1),
		.rs2    (rs2),
		.wb     (wb),
		.rf_rs1 (rf_rs1),
		.rf_rs2 (rf_rs2)
	);

	csr_file #(
		.VENDOR_ID (VENDOR_ID),
		.ARCH_ID   (ARCH_ID)
	) u_csr (
		.clk       (clk),
		.rst       (rst),
		.csr_rd_id (csr_rd_id),
		.wb        (wb),
		.csr_val   (csr_val)
	);

endmodule

/* dv/id_checker.sv */
module id_checker import rv_pkg::*; #(
	parameter logic [31:0] VENDOR_ID = 32'h0000_0000,
	parameter logic [31:0] ARCH_ID   = 32'h0000_0000
) (
	input  logic       clk,
	input  logic       rst,
	input  fetch_t     fetch,
	input  logic       in_valid,
	input  logic       in_ready,
	input  decoded_t   dec,
	input  logic       out_valid,
	input  logic       out_ready,
	input  pipe_slot_t slots [NUM_SLOTS],
	input  wb_t        wb,
	input  int         test_num,
	output int         errors,
	output int         checks
);
	timeunit 1ns;
	timeprecision 100ps;

	logic [31:0] shadow_regs [16];
	logic [31:0] shadow_csrs [8]; // Indexed by csr_id_e
	int          err_count = 0;
	int          check_count = 0;
	logic [31:0] word;
	logic [31:0] src_a;
	logic [31:0] src_b;
	logic        exp_stall;
	decoded_t    exp_dec;

	assign errors = err_count;
	assign checks = check_count;

	// ----------------------------------------
	// Shadow state follows write-back on the same edge
	// ----------------------------------------
	always @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				shadow_regs[i] <= 32'd0;
			end
			for (int i = 0; i < 8; i++) begin
				shadow_csrs[i] <= 32'd0;
			end
		end else begin
			if (wb.rd_we && wb.rd != 4'd0) begin
				shadow_regs[wb.rd] <= wb.rd_data;
			end
			if (wb.csr_we && wb.csr_id inside {CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE}) begin
				shadow_csrs[wb.csr_id] <= wb.csr_data;
			end
		end
	end

	function automatic csr_id_e csr_of_addr(input logic [11:0] addr);
		case (addr)
			CSR_ADDR_MSTATUS:   return CSR_MSTATUS;
			CSR_ADDR_MTVEC:     return CSR_MTVEC;
			CSR_ADDR_MEPC:      return CSR_MEPC;
			CSR_ADDR_MCAUSE:    return CSR_MCAUSE;
			CSR_ADDR_MVENDORID: return CSR_MVENDORID;
			CSR_ADDR_MARCHID:   return CSR_MARCHID;
			default:            return CSR_NONE;
		endcase
	endfunction

	function automatic csr_id_e csr_read_id(input logic [31:0] w);
		if (w[6:0] != OPC_SYSTEM)
			return CSR_NONE;
		if (w[14:12] != 3'b000)
			return csr_of_addr(w[31:20]);
		if (w[31:20] == F12_ECALL)
			return CSR_MTVEC; // Trap vector
		if (w[31:20] == F12_MRET)
			return CSR_MEPC;
		return CSR_NONE;
	endfunction

	function automatic logic [31:0] csr_value(input csr_id_e id);
		case (id)
			CSR_MVENDORID: return VENDOR_ID;
			CSR_MARCHID:   return ARCH_ID;
			CSR_NONE:      return 32'd0;
			default:       return shadow_csrs[id];
		endcase
	endfunction

	// Youngest forwardable slot, else the mirrored register
	function automatic logic [31:0] operand(input logic [3:0] r);
		logic [31:0] val;
		logic        found;
		val   = shadow_regs[r];
		found = 1'b0;
		for (int i = STAGE_EXU; i <= STAGE_WBU; i++) begin
			if (!found && r != 4'd0 && slots[i].rd_valid && slots[i].rd == r &&
				slots[i].fwd_valid) begin
				val   = slots[i].fwd_data;
				found = 1'b1;
			end
		end
		return val;
	endfunction

	function automatic logic expect_stall(input logic [31:0] w);
		logic       use1;
		logic       use2;
		logic       is_csrrs;
		logic       blocked;
		logic [2:0] f3;
		f3       = w[14:12];
		use1     = 1'b0;
		use2     = 1'b0;
		blocked  = 1'b0;
		is_csrrs = (w[6:0] == OPC_SYSTEM) && (f3 == 3'b010);
		case (w[6:0])
			OPC_OP, OPC_STORE, OPC_BRANCH: begin
				use1 = 1'b1;
				use2 = 1'b1;
			end
			OPC_OP_IMM, OPC_LOAD, OPC_JALR: use1 = 1'b1;
			OPC_SYSTEM: use1 = (f3 == 3'b001) || (f3 == 3'b010);
			default: ;
		endcase
		for (int i = 0; i < NUM_SLOTS; i++) begin
			if (use1 && w[18:15] != 4'd0 && slots[i].rd_valid && slots[i].rd == w[18:15] &&
				!slots[i].fwd_valid)
				blocked = 1'b1;
			if (use2 && w[23:20] != 4'd0 && slots[i].rd_valid && slots[i].rd == w[23:20] &&
				!slots[i].fwd_valid)
				blocked = 1'b1;
			if (is_csrrs && csr_read_id(w) != CSR_NONE && slots[i].csr_valid &&
				slots[i].csr_id == csr_read_id(w))
				blocked = 1'b1; // No CSR forwarding
		end
		return blocked;
	endfunction

	// ----------------------------------------
	// Reference decode
	// ----------------------------------------
	function automatic decoded_t ref_decode(input logic [31:0] w, input logic [31:0] pc,
		input logic [31:0] v1, input logic [31:0] v2, input logic [31:0] cv);
		decoded_t    d;
		logic [2:0]  f3;
		logic [11:0] f12;
		logic [31:0] imm_i;
		logic [31:0] imm_s;
		logic [31:0] imm_b;
		logic [31:0] imm_u;
		logic [31:0] imm_j;
		f3    = w[14:12];
		f12   = w[31:20];
		imm_i = {{20{w[31]}}, w[31:20]};
		imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
		imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
		imm_u = {w[31:12], 12'h000};
		imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
		d            = '0; // ADD and no memory access
		d.pc         = pc;
		d.rd         = w[10:7];
		d.src1       = v1;
		d.src2       = v2;
		d.store_data = v2;
		d.csr_rd_id  = csr_read_id(w);
		if (w[6:0] == OPC_SYSTEM && f3 != 3'b000)
			d.csr_wr_id = d.csr_rd_id;
		else if (w[6:0] == OPC_SYSTEM && f12 == F12_ECALL)
			d.csr_wr_id = CSR_MEPC;
		case (w[6:0])
			OPC_OP: begin
				d.reg_write = 1'b1;
				if (w[30])
					d.alu_op = (f3 == 3'b000) ? ALU_SUB : ALU_SRA;
				else
					d.alu_op = alu_op_e'({1'b0, f3});
			end
			OPC_OP_IMM: begin
				d.imm       = imm_i;
				d.src2      = imm_i;
				d.reg_write = 1'b1;
				d.alu_op    = (f3 == 3'b101 && w[30]) ? ALU_SRA : alu_op_e'({1'b0, f3});
			end
			OPC_LOAD: begin
				d.imm       = imm_i;
				d.src2      = imm_i;
				d.reg_write = 1'b1;
				case (f3)
					3'b000:  d.mem_read = MEM_RD_BYTE;
					3'b001:  d.mem_read = MEM_RD_HALF;
					3'b010:  d.mem_read = MEM_RD_WORD;
					3'b100:  d.mem_read = MEM_RD_BYTE_U;
					3'b101:  d.mem_read = MEM_RD_HALF_U;
					default: d.mem_read = MEM_RD_NONE;
				endcase
			end
			OPC_STORE: begin
				d.imm  = imm_s;
				d.src2 = imm_s;
				case (f3)
					3'b000:  d.mem_write = MEM_WR_BYTE;
					3'b001:  d.mem_write = MEM_WR_HALF;
					3'b010:  d.mem_write = MEM_WR_WORD;
					default: d.mem_write = MEM_WR_NONE;
				endcase
			end
			OPC_BRANCH: begin
				d.imm = imm_b;
				case (f3)
					3'b000:  d.alu_op = ALU_EQ;
					3'b001:  d.alu_op = ALU_NEQ;
					3'b100:  d.alu_op = ALU_LT;
					3'b101:  d.alu_op = ALU_GE;
					3'b110:  d.alu_op = ALU_LTU;
					3'b111:  d.alu_op = ALU_GEU;
					default: d.alu_op = ALU_ADD;
				endcase
			end
			OPC_JAL: begin
				d.imm       = imm_j;
				d.src1      = pc;
				d.src2      = imm_j;
				d.is_jump   = 1'b1;
				d.is_jalr   = 1'b1;
				d.reg_write = 1'b1;
			end
			OPC_JALR: begin
				d.imm       = imm_i;
				d.src2      = imm_i;
				d.is_jump   = 1'b1;
				d.is_jalr   = 1'b1;
				d.reg_write = 1'b1;
			end
			OPC_LUI, OPC_AUIPC: begin
				d.imm       = imm_u;
				d.src1      = (w[6:0] == OPC_LUI) ? 32'd0 : pc;
				d.src2      = imm_u;
				d.reg_write = 1'b1;
			end
			OPC_MISC_MEM: begin
				if (f3 == 3'b001) begin
					d.imm     = 32'd4;
					d.fence_i = 1'b1;
				end
			end
			OPC_SYSTEM: begin
				d.imm = imm_i;
				if (f3 == 3'b000 && f12 == F12_EBREAK) begin
					d.ebreak = 1'b1;
				end else if (f3 == 3'b000 && f12 == F12_MRET) begin
					d.mret = 1'b1;
					d.src1 = cv;
					d.src2 = 32'd0;
				end else if (f3 == 3'b000 && f12 == F12_ECALL) begin
					d.ecall     = 1'b1;
					d.csr_write = 1'b1;
					d.is_jalr   = 1'b1;
					d.src1      = cv;
					d.src2      = 32'd0;
				end else if (f3 == 3'b001) begin
					d.csr_write = 1'b1;
					d.src2      = 32'd0;
				end else if (f3 == 3'b010) begin
					d.reg_write = 1'b1;
					d.src2      = cv;
					d.alu_op    = ALU_OR;
				end
			end
			default: ;
		endcase
		return d;
	endfunction

	function automatic logic [7:0] flags_of(input decoded_t d);
		return {d.reg_write, d.csr_write, d.is_jump, d.is_jalr, d.ecall, d.ebreak, d.mret,
			d.fence_i};
	endfunction

	task automatic check_value(input string what, input logic [31:0] exp,
		input logic [31:0] act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("CHECK FAILED test_%0d %s: expected %h, actual %h", test_num, what, exp,
				act);
		end
	endtask

	// ----------------------------------------
	// Compare in the middle of the cycle
	// ----------------------------------------
	always @(negedge clk) begin
		if (!rst) begin
			word      = fetch.inst;
			src_a     = operand(word[18:15]);
			src_b     = operand(word[23:20]);
			exp_stall = expect_stall(word);
			exp_dec   = ref_decode(word, fetch.pc, src_a, src_b, csr_value(csr_read_id(word)));
			check_value("in_ready", 32'(out_ready && !exp_stall), 32'(in_ready));
			check_value("out_valid", 32'(in_valid && out_ready && !exp_stall), 32'(out_valid));
			if (in_valid) begin
				check_value("pc", exp_dec.pc, dec.pc);
				check_value("src1", exp_dec.src1, dec.src1);
				check_value("src2", exp_dec.src2, dec.src2);
				check_value("store_data", exp_dec.store_data, dec.store_data);
				check_value("imm", exp_dec.imm, dec.imm);
				check_value("rd", 32'(exp_dec.rd), 32'(dec.rd));
				check_value("alu_op", 32'(exp_dec.alu_op), 32'(dec.alu_op));
				check_value("mem_read", 32'(exp_dec.mem_read), 32'(dec.mem_read));
				check_value("mem_write", 32'(exp_dec.mem_write), 32'(dec.mem_write));
				check_value("csr_rd_id", 32'(exp_dec.csr_rd_id), 32'(dec.csr_rd_id));
				check_value("csr_wr_id", 32'(exp_dec.csr_wr_id), 32'(dec.csr_wr_id));
				check_value("flags", 32'(flags_of(exp_dec)), 32'(flags_of(dec)));
			end
		end
	end

endmodule

/* dv/tb_top.sv */
module tb_top import rv_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [31:0] VENDOR_ID    = 32'h0000_0e5a;
	localparam logic [31:0] ARCH_ID      = 32'h0000_0021;
	localparam int          RESET_CYCLES = 8;
	localparam int          FILL_CYCLES  = 16;
	localparam int          NUM_TESTS    = 600;
	localparam int          MAX_CYCLES   = 2000; // 24 setup cycles, 600 tests at up to 3 cycles

	logic       clk = 1'b0;
	logic       rst;
	fetch_t     fetch;
	logic       in_valid;
	logic       in_ready;
	decoded_t   dec;
	logic       out_valid;
	logic       out_ready;
	pipe_slot_t slots [NUM_SLOTS];
	wb_t        wb;
	int         seed = 32'h1740_64b4;
	int         test_num = 0;
	int         cycles = 0;
	int         errors;
	int         checks;
	logic       accepted;

	always #4 clk = ~clk;

	id_top #(
		.VENDOR_ID (VENDOR_ID),
		.ARCH_ID   (ARCH_ID)
	) id_top_i (
		.clk       (clk),
		.rst       (rst),
		.fetch     (fetch),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.dec       (dec),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.slots     (slots),
		.wb        (wb)
	);

	id_checker #(
		.VENDOR_ID (VENDOR_ID),
		.ARCH_ID   (ARCH_ID)
	) chk_i (
		.clk       (clk),
		.rst       (rst),
		.fetch     (fetch),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.dec       (dec),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.slots     (slots),
		.wb        (wb),
		.test_num  (test_num),
		.errors    (errors),
		.checks    (checks)
	);

	function automatic logic [31:0] rand_word();
		return $random(seed);
	endfunction

	function automatic logic [11:0] pick_csr_addr(input logic [31:0] r);
		case (r % 6)
			0:       return CSR_ADDR_MSTATUS;
			1:       return CSR_ADDR_MTVEC;
			2:       return CSR_ADDR_MEPC;
			3:       return CSR_ADDR_MCAUSE;
			4:       return CSR_ADDR_MVENDORID;
			default: return CSR_ADDR_MARCHID;
		endcase
	endfunction

	// ----------------------------------------
	// Legal RV32E instruction words
	// ----------------------------------------
	function automatic logic [31:0] make_inst();
		logic [31:0] r;
		logic [31:0] r2;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [11:0] imm12;
		logic [31:0] word;
		int          kind;
		r     = rand_word();
		r2    = rand_word();
		kind  = rand_word() % 13;
		rd    = {1'b0, r[3:0]}; // x0 to x15 only
		rs1   = {1'b0, r[7:4]};
		rs2   = {1'b0, r[11:8]};
		f3    = r[14:12];
		imm12 = r[31:20];
		case (kind)
			0: word = {((f3 == 3'b000 || f3 == 3'b101) && r2[0]) ? 7'h20 : 7'h00, rs2, rs1, f3,
				rd, OPC_OP};
			1: begin
				if (f3 == 3'b001)
					imm12[11:5] = 7'h00;
				else if (f3 == 3'b101)
					imm12[11:5] = r2[0] ? 7'h20 : 7'h00; // SRAI or SRLI
				word = {imm12, rs1, f3, rd, OPC_OP_IMM};
			end
			2: begin
				if (f3 == 3'b011 || f3 > 3'b101)
					f3 = 3'b010;
				word = {imm12, rs1, f3, rd, OPC_LOAD};
			end
			3: begin
				if (f3 > 3'b010)
					f3 = 3'b010;
				word = {imm12[11:5], rs2, rs1, f3, imm12[4:0], OPC_STORE};
			end
			4: begin
				f3   = {f3[2], f3[1] & f3[2], f3[0]}; // No funct3 2 or 3
				word = {imm12[11:5], rs2, rs1, f3, imm12[4:0], OPC_BRANCH};
			end
			5: word = {r2[31:12], rd, OPC_JAL};
			6: word = {imm12, rs1, 3'b000, rd, OPC_JALR};
			7: word = {r2[31:12], rd, OPC_LUI};
			8: word = {r2[31:12], rd, OPC_AUIPC};
			9: word = {17'd0, 3'b001, 5'd0, OPC_MISC_MEM};
			10: begin
				case (r2[1:0])
					2'd1:    word = {F12_EBREAK, 13'd0, OPC_SYSTEM};
					2'd2:    word = {F12_MRET, 13'd0, OPC_SYSTEM};
					default: word = {F12_ECALL, 13'd0, OPC_SYSTEM};
				endcase
			end
			11, 12: word = {pick_csr_addr(r2), rs1, (kind == 11) ? 3'b001 : 3'b010, rd,
				OPC_SYSTEM};
			default: word = 32'h0000_0013;
		endcase
		return word;
	endfunction

	// Slots lean toward the current sources so hazards come up often
	task automatic drive_cycle_inputs();
		logic [31:0] r;
		logic [31:0] w;
		w = fetch.inst;
		for (int i = 0; i < NUM_SLOTS; i++) begin
			r = rand_word();
			case (r[1:0])
				2'd1:    slots[i].rd = w[18:15];
				2'd2:    slots[i].rd = w[23:20];
				default: slots[i].rd = r[15:12];
			endcase
			slots[i].rd_valid  = r[2];
			slots[i].fwd_valid = (r[4:3] != 2'b00);
			slots[i].csr_valid = (r[6:5] == 2'b00);
			slots[i].csr_id    = csr_id_e'((r[9:7] == 3'd7) ? 3'd1 : r[9:7]);
			slots[i].fwd_data  = rand_word();
		end
		r           = rand_word();
		wb.rd_we    = r[0];
		wb.rd       = r[4:1]; // x0 included
		wb.rd_data  = rand_word();
		wb.csr_we   = r[5] && r[6];
		wb.csr_id   = csr_id_e'((r[9:7] == 3'd7) ? 3'd1 : r[9:7]);
		wb.csr_data = rand_word();
		out_ready   = (r[12:10] != 3'b000);
	endtask

	task automatic clear_inputs();
		fetch     = '0;
		in_valid  = 1'b0;
		out_ready = 1'b0;
		wb        = '0;
		for (int i = 0; i < NUM_SLOTS; i++) begin
			slots[i] = '0;
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
	endtask

	// ----------------------------------------
	// Run length guard
	// ----------------------------------------
	initial begin
		while (cycles < MAX_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
		$display("Finished with errors");
		$finish;
	end

	initial begin
		rst = 1'b1;
		clear_inputs();
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;
		// Fill all registers, x0 too, and the writable CSRs
		for (int i = 0; i < FILL_CYCLES; i++) begin
			wb.rd_we    = 1'b1;
			wb.rd       = 4'(i);
			wb.rd_data  = rand_word();
			wb.csr_we   = (i < 4);
			wb.csr_id   = csr_id_e'(3'(i + 1));
			wb.csr_data = rand_word();
			out_ready   = 1'b1;
			next_cycle();
		end
		in_valid = 1'b1;
		for (int t = 1; t <= NUM_TESTS; t++) begin
			test_num   = t;
			fetch.inst = make_inst();
			fetch.pc   = rand_word() & 32'hffff_fffc;
			accepted   = 1'b0;
			while (!accepted) begin // Hold the word until taken
				drive_cycle_inputs();
				@(negedge clk);
				accepted = in_ready;
				next_cycle();
			end
		end
		clear_inputs();
		repeat (2) next_cycle();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

/* all.f */
hdl/rv_pkg.sv
hdl/inst_decoder.sv
hdl/hazard_fwd.sv
hdl/reg_file.sv
hdl/csr_file.sv
hdl/id_top.sv
dv/id_checker.sv
dv/tb_top.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_top
FILELIST   := all.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
